// File: fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ======================================================================
// Widths
// ======================================================================

// Address and instruction word width
`define FETCH_XLEN 32
// Compressed instruction width, half a word
`define FETCH_HLEN 16

// ======================================================================
// Address map
// ======================================================================

// First PC after reset
`define FETCH_RESET_VECTOR 32'h0000_1000

// Executable window, base inclusive and limit exclusive
`define FETCH_EXEC_BASE 32'h0000_0000
`define FETCH_EXEC_LIMIT 32'h0001_0000

// ======================================================================
// Special instruction encodings
// ======================================================================

`define FETCH_INSTR_EBREAK 32'h0010_0073
`define FETCH_INSTR_CEBREAK 16'h9002
`define FETCH_INSTR_ECALL 32'h0000_0073
// All-ones word and zero halfword are reserved as illegal
`define FETCH_INSTR_ILLEGAL32 32'hFFFF_FFFF
`define FETCH_INSTR_ILLEGAL16 16'h0000

`endif

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // ======================================================================
  // Exception codes handed to decode
  // ======================================================================

  // Listed from highest to lowest priority after NO_EXC
  typedef enum logic [2:0] {
    NO_EXC,
    BREAKPOINT,
    INSTR_MISALIGNED,
    INSTR_ACCESS_FAULT,
    ILLEGAL_INSTR,
    EBREAK,
    ECALL
  } exc_e;

  // ======================================================================
  // Faults known from the PC alone
  // ======================================================================

  // Resolved in the PC generator, one code per PC
  typedef enum logic [1:0] {
    PC_OK,
    PC_BREAKPOINT,
    PC_MISALIGNED,
    PC_ACCESS_FAULT
  } pc_exc_e;

endpackage

`default_nettype wire

// File: fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_pc_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic [`FETCH_XLEN-1:0] flush_pc_i,
  input  logic                   trap_active_i,
  input  logic [`FETCH_XLEN-1:0] mtvec_i,
  input  logic                   misa_c_i,
  input  logic                   bkpt_en_i,
  input  logic [`FETCH_XLEN-1:0] bkpt_addr_i,
  input  logic                   advance_i,
  input  logic                   is_comp_i,
  output logic [`FETCH_XLEN-1:0] pc_o,
  output fetch_pkg::pc_exc_e     pc_exc_o,
  output logic                   redirect_o
);

  // Sequential steps for 16-bit and 32-bit instructions
  localparam logic [`FETCH_XLEN-1:0] STEP_C = 2;
  localparam logic [`FETCH_XLEN-1:0] STEP_W = 4;

  logic [`FETCH_XLEN-1:0] pc_next;
  logic [`FETCH_XLEN-1:0] win_offset;
  logic                   pc_en;
  logic                   bkpt_hit;
  logic                   misaligned;
  logic                   outside;
  fetch_pkg::pc_exc_e     pc_exc_next;

  // ======================================================================
  // Next PC selection
  // ======================================================================
  always_comb begin
    redirect_o = flush_i || trap_active_i;
    pc_en      = redirect_o || advance_i;

    // Flush beats trap, trap beats sequential
    if (flush_i) begin
      pc_next = flush_pc_i;
    end else if (trap_active_i) begin
      pc_next = mtvec_i;
    end else begin
      pc_next = pc_o + (is_comp_i ? STEP_C : STEP_W);
    end
  end

  // ======================================================================
  // PC fault lookup on the next PC
  // ======================================================================
  always_comb begin
    bkpt_hit   = bkpt_en_i && (pc_next == bkpt_addr_i);
    // Halfword alignment with C, word alignment without
    misaligned = misa_c_i ? pc_next[0] : (pc_next[1:0] != 2'b00);
    // Single unsigned compare covers both window edges
    win_offset = pc_next - `FETCH_EXEC_BASE;
    outside    = win_offset >= (`FETCH_EXEC_LIMIT - `FETCH_EXEC_BASE);

    if (bkpt_hit) begin
      pc_exc_next = fetch_pkg::PC_BREAKPOINT;
    end else if (misaligned) begin
      pc_exc_next = fetch_pkg::PC_MISALIGNED;
    end else if (outside) begin
      pc_exc_next = fetch_pkg::PC_ACCESS_FAULT;
    end else begin
      pc_exc_next = fetch_pkg::PC_OK;
    end
  end

  // PC and its fault move together
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pc_o     <= `FETCH_RESET_VECTOR;
      pc_exc_o <= fetch_pkg::PC_OK;
    end else if (pc_en) begin
      pc_o     <= pc_next;
      pc_exc_o <= pc_exc_next;
    end
  end

  // Align must hold back its transfer while a redirect is in progress
  a_no_advance_on_redirect: assert property (
    @(posedge clk_i) disable iff (!rst_ni) advance_i |-> !redirect_o
  ) else $error("advance_i high in a redirect cycle, pc=%h", pc_o);

endmodule

`default_nettype wire

// File: fetch_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_align (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`FETCH_XLEN-1:0] pc_i,
  input  logic                   redirect_i,
  input  logic                   misa_c_i,
  input  logic                   mem_req_ready_i,
  input  logic                   mem_rsp_valid_i,
  input  logic [`FETCH_XLEN-1:0] mem_rsp_data_i,
  input  logic                   ins_ready_i,
  output logic                   mem_req_valid_o,
  output logic [`FETCH_XLEN-1:0] mem_req_addr_o,
  output logic                   ins_valid_o,
  output logic [`FETCH_XLEN-1:0] ins_data_o,
  output logic                   ins_is_comp_o,
  output logic                   advance_o
);

  // Word address width
  localparam int unsigned WA = `FETCH_XLEN - 2;

  // Buffered word and its tag
  logic                   buf_valid;
  logic [WA-1:0]          buf_addr;
  logic [`FETCH_XLEN-1:0] buf_data;
  // Upper half of the previous word, for straddling instructions
  logic                   lo_valid;
  logic [WA-1:0]          lo_addr;
  logic [`FETCH_HLEN-1:0] lo_half;
  // Request tracking
  logic                   req_valid;
  logic [WA-1:0]          req_word;
  logic                   pend;
  logic                   discard;

  logic [WA-1:0]          cur_word;
  logic [WA-1:0]          nxt_word;
  logic                   hit_cur;
  logic                   hit_nxt;
  logic                   lo_hit;
  logic                   lo_avail;
  logic                   hi_avail;
  logic [`FETCH_HLEN-1:0] lo16;
  logic [`FETCH_HLEN-1:0] hi16;
  logic                   comp;
  logic                   ins_avail;
  logic [WA-1:0]          need_addr;
  logic                   issue;
  logic                   stale_req;
  logic                   rsp_keep;

  // ======================================================================
  // Instruction assembly at the current PC
  // ======================================================================
  always_comb begin
    cur_word = pc_i[`FETCH_XLEN-1:2];
    nxt_word = cur_word + 1'b1;
    hit_cur  = buf_valid && (buf_addr == cur_word);
    hit_nxt  = buf_valid && (buf_addr == nxt_word);
    lo_hit   = lo_valid && (lo_addr == cur_word);

    if (pc_i[1]) begin
      // Upper halfword start, second half lives in the next word
      lo_avail = hit_cur || lo_hit;
      lo16     = hit_cur ? buf_data[`FETCH_XLEN-1:`FETCH_HLEN] : lo_half;
      hi_avail = hit_nxt;
      hi16     = buf_data[`FETCH_HLEN-1:0];
    end else begin
      lo_avail = hit_cur;
      lo16     = buf_data[`FETCH_HLEN-1:0];
      hi_avail = hit_cur;
      hi16     = buf_data[`FETCH_XLEN-1:`FETCH_HLEN];
    end

    // Low bits 11 mark a 32-bit instruction
    comp      = misa_c_i && (lo16[1:0] != 2'b11);
    ins_avail = lo_avail && (comp || hi_avail);
    // Fetch the missing half, first half takes precedence
    need_addr = lo_avail ? nxt_word : cur_word;

    ins_valid_o   = ins_avail && !redirect_i;
    ins_data_o    = comp ? {{`FETCH_HLEN{1'b0}}, lo16} : {hi16, lo16};
    ins_is_comp_o = comp;
    advance_o     = ins_valid_o && ins_ready_i;
  end

  // ======================================================================
  // Memory request and response handling
  // ======================================================================
  always_comb begin
    mem_req_valid_o = req_valid;
    mem_req_addr_o  = {req_word, 2'b00};
    // One request at a time, none raised from a stale PC
    issue     = !req_valid && !pend && !ins_avail && !redirect_i;
    // Anything still to come back belongs to the old path
    stale_req = req_valid || (pend && !mem_rsp_valid_i);
    rsp_keep  = mem_rsp_valid_i && !discard && !redirect_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_valid <= 1'b0;
      pend      <= 1'b0;
      discard   <= 1'b0;
      buf_valid <= 1'b0;
      lo_valid  <= 1'b0;
    end else begin
      if (mem_rsp_valid_i) begin
        pend <= 1'b0;
      end
      if (req_valid && mem_req_ready_i) begin
        req_valid <= 1'b0;
        pend      <= 1'b1;
      end else if (issue) begin
        req_valid <= 1'b1;
      end

      if (redirect_i && stale_req) begin
        discard <= 1'b1;
      end else if (mem_rsp_valid_i) begin
        discard <= 1'b0;
      end

      // Redirect empties the buffer, a kept response refills it
      if (redirect_i) begin
        buf_valid <= 1'b0;
        lo_valid  <= 1'b0;
      end else if (rsp_keep) begin
        buf_valid <= 1'b1;
        lo_valid  <= buf_valid;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (issue) begin
      req_word <= need_addr;
    end
    if (rsp_keep) begin
      buf_data <= mem_rsp_data_i;
      // Address is still held in req_word while pending
      buf_addr <= req_word;
      lo_half  <= buf_data[`FETCH_XLEN-1:`FETCH_HLEN];
      lo_addr  <= buf_addr;
    end
  end

  a_req_addr_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o)
  ) else $error("Request dropped or moved, addr=%h", mem_req_addr_o);

  // Memory side must not answer without an accepted request
  a_rsp_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_rsp_valid_i |-> pend
  ) else $error("Response with nothing outstanding, data=%h", mem_rsp_data_i);

endmodule

`default_nettype wire

// File: fetch_exc_check.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_exc_check (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   redirect_i,
  input  logic                   ins_valid_i,
  input  logic [`FETCH_XLEN-1:0] ins_data_i,
  input  logic                   ins_is_comp_i,
  input  logic [`FETCH_XLEN-1:0] pc_i,
  input  fetch_pkg::pc_exc_e     pc_exc_i,
  input  logic                   out_ready_i,
  output logic                   ins_ready_o,
  output logic                   out_valid_o,
  output logic [`FETCH_XLEN-1:0] out_pc_o,
  output logic [`FETCH_XLEN-1:0] out_instr_o,
  output logic                   out_is_comp_o,
  output fetch_pkg::exc_e        out_exc_o
);

  logic [`FETCH_HLEN-1:0] half;
  logic                   is_illegal;
  logic                   is_ebreak;
  logic                   is_ecall;
  logic                   load;
  fetch_pkg::exc_e        exc_d;

  // ======================================================================
  // Exception classification
  // ======================================================================
  always_comb begin
    half       = ins_data_i[`FETCH_HLEN-1:0];
    is_illegal = ins_is_comp_i ? (half == `FETCH_INSTR_ILLEGAL16)
                               : (ins_data_i == `FETCH_INSTR_ILLEGAL32);
    is_ebreak  = ins_is_comp_i ? (half == `FETCH_INSTR_CEBREAK)
                               : (ins_data_i == `FETCH_INSTR_EBREAK);
    // No compressed form of ECALL
    is_ecall   = !ins_is_comp_i && (ins_data_i == `FETCH_INSTR_ECALL);

    // PC faults outrank anything found in the instruction bits
    case (pc_exc_i)
      fetch_pkg::PC_BREAKPOINT:   exc_d = fetch_pkg::BREAKPOINT;
      fetch_pkg::PC_MISALIGNED:   exc_d = fetch_pkg::INSTR_MISALIGNED;
      fetch_pkg::PC_ACCESS_FAULT: exc_d = fetch_pkg::INSTR_ACCESS_FAULT;
      default: begin
        if (is_illegal) begin
          exc_d = fetch_pkg::ILLEGAL_INSTR;
        end else if (is_ebreak) begin
          exc_d = fetch_pkg::EBREAK;
        end else if (is_ecall) begin
          exc_d = fetch_pkg::ECALL;
        end else begin
          exc_d = fetch_pkg::NO_EXC;
        end
      end
    endcase
  end

  // ======================================================================
  // Output register toward decode
  // ======================================================================

  // Free slot, or the held item leaves this cycle
  assign ins_ready_o = !out_valid_o || out_ready_i;
  assign load        = ins_valid_i && ins_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (redirect_i) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_pc_o      <= pc_i;
      out_instr_o   <= ins_data_i;
      out_is_comp_o <= ins_is_comp_i;
      out_exc_o     <= exc_d;
    end
  end

  // Held item stays put until decode takes it, unless a redirect kills it
  a_out_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i && !redirect_i |=>
      out_valid_o && $stable(out_pc_o) && $stable(out_instr_o) &&
      $stable(out_is_comp_o) && $stable(out_exc_o)
  ) else $error("Output changed under back-pressure, pc=%h instr=%h", out_pc_o, out_instr_o);

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Redirect and control
  input  logic                   flush_i,
  input  logic [`FETCH_XLEN-1:0] flush_pc_i,
  input  logic                   trap_active_i,
  input  logic [`FETCH_XLEN-1:0] mtvec_i,
  input  logic                   misa_c_i,
  input  logic                   bkpt_en_i,
  input  logic [`FETCH_XLEN-1:0] bkpt_addr_i,
  // Memory port
  output logic                   mem_req_valid_o,
  output logic [`FETCH_XLEN-1:0] mem_req_addr_o,
  input  logic                   mem_req_ready_i,
  input  logic                   mem_rsp_valid_i,
  input  logic [`FETCH_XLEN-1:0] mem_rsp_data_i,
  // Toward decode
  output logic                   out_valid_o,
  output logic [`FETCH_XLEN-1:0] out_pc_o,
  output logic [`FETCH_XLEN-1:0] out_instr_o,
  output logic                   out_is_comp_o,
  output fetch_pkg::exc_e        out_exc_o,
  input  logic                   out_ready_i
);

  logic [`FETCH_XLEN-1:0] pc;
  fetch_pkg::pc_exc_e     pc_exc;
  logic                   redirect;
  logic                   advance;
  logic                   is_comp;
  logic                   ins_valid;
  logic [`FETCH_XLEN-1:0] ins_data;
  logic                   ins_ready;

  // ======================================================================
  // PC generator
  // ======================================================================
  fetch_pc_gen u_pc_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .flush_pc_i   (flush_pc_i),
    .trap_active_i(trap_active_i),
    .mtvec_i      (mtvec_i),
    .misa_c_i     (misa_c_i),
    .bkpt_en_i    (bkpt_en_i),
    .bkpt_addr_i  (bkpt_addr_i),
    .advance_i    (advance),
    .is_comp_i    (is_comp),
    .pc_o         (pc),
    .pc_exc_o     (pc_exc),
    .redirect_o   (redirect)
  );

  // ======================================================================
  // Align unit, length also feeds the PC step
  // ======================================================================
  fetch_align u_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pc_i           (pc),
    .redirect_i     (redirect),
    .misa_c_i       (misa_c_i),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_data_i (mem_rsp_data_i),
    .ins_ready_i    (ins_ready),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_addr_o (mem_req_addr_o),
    .ins_valid_o    (ins_valid),
    .ins_data_o     (ins_data),
    .ins_is_comp_o  (is_comp),
    .advance_o      (advance)
  );

  // ======================================================================
  // Exception stage and output register
  // ======================================================================
  fetch_exc_check u_exc_check (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .redirect_i   (redirect),
    .ins_valid_i  (ins_valid),
    .ins_data_i   (ins_data),
    .ins_is_comp_i(is_comp),
    .pc_i         (pc),
    .pc_exc_i     (pc_exc),
    .out_ready_i  (out_ready_i),
    .ins_ready_o  (ins_ready),
    .out_valid_o  (out_valid_o),
    .out_pc_o     (out_pc_o),
    .out_instr_o  (out_instr_o),
    .out_is_comp_o(out_is_comp_o),
    .out_exc_o    (out_exc_o)
  );

endmodule

`default_nettype wire

// File: tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module tb_fetch;

  localparam int NUM_TESTS = 5;
  // Tests x 200 instructions x 12 cycles x 8 ns
  localparam int WATCHDOG_NS = NUM_TESTS * 200 * 12 * 8;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   flush_i;
  logic [`FETCH_XLEN-1:0] flush_pc_i;
  logic                   trap_active_i;
  logic [`FETCH_XLEN-1:0] mtvec_i;
  logic                   misa_c_i;
  logic                   bkpt_en_i;
  logic [`FETCH_XLEN-1:0] bkpt_addr_i;
  logic                   mem_req_valid_o;
  logic [`FETCH_XLEN-1:0] mem_req_addr_o;
  logic                   mem_req_ready_i;
  logic                   mem_rsp_valid_i;
  logic [`FETCH_XLEN-1:0] mem_rsp_data_i;
  logic                   out_valid_o;
  logic [`FETCH_XLEN-1:0] out_pc_o;
  logic [`FETCH_XLEN-1:0] out_instr_o;
  logic                   out_is_comp_o;
  fetch_pkg::exc_e        out_exc_o;
  logic                   out_ready_i;

  // Reference model state, owned by the env process
  logic [`FETCH_XLEN-1:0] exp_pc;
  logic [`FETCH_XLEN-1:0] exp_instr;
  logic                   exp_comp;
  fetch_pkg::exc_e        exp_exc;
  logic                   model_c;
  logic                   model_be;
  logic [`FETCH_XLEN-1:0] model_ba;
  int                     n_out = 0;
  int                     errors = 0;
  int                     tests_run = 0;
  int                     tests_failed = 0;
  logic [31:0]            lfsr = 32'd66659;

  fetch_top UUT (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .flush_i(flush_i), .flush_pc_i(flush_pc_i),
    .trap_active_i(trap_active_i), .mtvec_i(mtvec_i), .misa_c_i(misa_c_i),
    .bkpt_en_i(bkpt_en_i), .bkpt_addr_i(bkpt_addr_i),
    .mem_req_valid_o(mem_req_valid_o), .mem_req_addr_o(mem_req_addr_o),
    .mem_req_ready_i(mem_req_ready_i), .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_data_i(mem_rsp_data_i),
    .out_valid_o(out_valid_o), .out_pc_o(out_pc_o), .out_instr_o(out_instr_o),
    .out_is_comp_o(out_is_comp_o), .out_exc_o(out_exc_o), .out_ready_i(out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ======================================================================
  // Random bits, memory contents and the expected item
  // ======================================================================

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:2], 2'b00};
    case (a)
      32'h3000: return `FETCH_INSTR_EBREAK;
      32'h3004: return `FETCH_INSTR_ECALL;
      32'h3008: return `FETCH_INSTR_ILLEGAL32;
      32'h300C: return 32'h0000_9002;
      default: begin
        // Compressed pairs, every fourth word a 32-bit op
        if (a >= 32'h2000 && a < 32'h3000) begin
          return (a[3:2] == 2'b11) ? 32'hABCD_1237 : 32'h4505_4501;
        end
        return 32'h0000_0013;
      end
    endcase
  endfunction

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    logic [31:0] w;
    w = mem_word(addr);
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  // Length, data and exception for the item at exp_pc
  task automatic expect_item();
    logic [15:0] lo;
    logic [15:0] hi;
    lo = half_at(exp_pc);
    hi = half_at(exp_pc + 32'd2);
    exp_comp  = model_c && (lo[1:0] != 2'b11);
    exp_instr = exp_comp ? {16'h0000, lo} : {hi, lo};
    // PC faults first, then what the bits say
    if (model_be && exp_pc == model_ba) begin
      exp_exc = fetch_pkg::BREAKPOINT;
    end else if (model_c ? exp_pc[0] : (exp_pc[1:0] != 2'b00)) begin
      exp_exc = fetch_pkg::INSTR_MISALIGNED;
    end else if (exp_pc < `FETCH_EXEC_BASE || exp_pc >= `FETCH_EXEC_LIMIT) begin
      exp_exc = fetch_pkg::INSTR_ACCESS_FAULT;
    end else if (exp_comp ? lo == `FETCH_INSTR_ILLEGAL16
                          : exp_instr == `FETCH_INSTR_ILLEGAL32) begin
      exp_exc = fetch_pkg::ILLEGAL_INSTR;
    end else if (exp_comp ? lo == `FETCH_INSTR_CEBREAK
                          : exp_instr == `FETCH_INSTR_EBREAK) begin
      exp_exc = fetch_pkg::EBREAK;
    end else if (!exp_comp && exp_instr == `FETCH_INSTR_ECALL) begin
      exp_exc = fetch_pkg::ECALL;
    end else begin
      exp_exc = fetch_pkg::NO_EXC;
    end
  endtask

  // ======================================================================
  // Memory, ready signals and reference model
  // ======================================================================
  initial begin : env
    logic        fire;
    logic        xfer;
    logic        redir;
    logic        busy;
    logic        b0;
    logic        b1;
    logic        s_c;
    logic        s_be;
    logic [31:0] s_ba;
    logic [31:0] fire_addr;
    logic [31:0] redir_pc;
    logic [31:0] rsp_addr;
    int          cnt;
    busy     = 1'b0;
    cnt      = 0;
    rsp_addr = '0;
    exp_pc   = `FETCH_RESET_VECTOR;
    model_c  = 1'b0;
    model_be = 1'b0;
    model_ba = '0;
    expect_item();
    forever begin
      // Sample mid-cycle where everything has settled
      @(negedge clk_i);
      fire      = rst_ni && mem_req_valid_o && mem_req_ready_i;
      fire_addr = mem_req_addr_o;
      xfer      = rst_ni && out_valid_o && out_ready_i;
      redir     = rst_ni && (flush_i || trap_active_i);
      redir_pc  = flush_i ? flush_pc_i : mtvec_i;
      s_c       = misa_c_i;
      s_be      = bkpt_en_i;
      s_ba      = bkpt_addr_i;
      @(posedge clk_i);
      #1;
      mem_rsp_valid_i = 1'b0;
      if (fire) begin
        // Latency of 1 to 4 cycles
        take_bit(b0);
        take_bit(b1);
        cnt      = 1 + int'({b1, b0});
        busy     = 1'b1;
        rsp_addr = fire_addr;
      end
      if (busy) begin
        cnt = cnt - 1;
        if (cnt == 0) begin
          mem_rsp_valid_i = 1'b1;
          mem_rsp_data_i  = mem_word(rsp_addr);
          busy            = 1'b0;
        end
      end
      // Ready high three times in four
      take_bit(b0);
      take_bit(b1);
      mem_req_ready_i = b0 | b1;
      take_bit(b0);
      take_bit(b1);
      out_ready_i = b0 | b1;
      // Step past a taken item, a redirect then overrides
      if (xfer) begin
        exp_pc = exp_pc + (exp_comp ? 32'd2 : 32'd4);
        n_out  = n_out + 1;
      end
      if (redir) begin
        exp_pc   = redir_pc;
        model_c  = s_c;
        model_be = s_be;
        model_ba = s_ba;
      end
      expect_item();
    end
  end

  // ======================================================================
  // Checks on every transfer toward decode
  // ======================================================================
  a_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && out_ready_i |-> out_pc_o == exp_pc)
  else begin
    errors++;
    $display("FAIL out_pc_o got %h expected %h", $sampled(out_pc_o), $sampled(exp_pc));
  end

  a_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && out_ready_i |-> out_instr_o == exp_instr)
  else begin
    errors++;
    $display("FAIL out_instr_o got %h expected %h at pc %h",
             $sampled(out_instr_o), $sampled(exp_instr), $sampled(out_pc_o));
  end

  a_comp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && out_ready_i |-> out_is_comp_o == exp_comp)
  else begin
    errors++;
    $display("FAIL out_is_comp_o got %h expected %h at pc %h",
             $sampled(out_is_comp_o), $sampled(exp_comp), $sampled(out_pc_o));
  end

  a_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && out_ready_i |-> out_exc_o == exp_exc)
  else begin
    errors++;
    $display("FAIL out_exc_o got %h expected %h at pc %h",
             $sampled(out_exc_o), $sampled(exp_exc), $sampled(out_pc_o));
  end

  // Held item must not move while decode stalls
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i && !flush_i && !trap_active_i |=>
      out_valid_o && $stable(out_pc_o) && $stable(out_instr_o) &&
      $stable(out_is_comp_o) && $stable(out_exc_o))
  else begin
    errors++;
    $display("Output changed or dropped while decode held it back, pc %h", $sampled(out_pc_o));
  end

  a_kill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i || trap_active_i |=> !out_valid_o)
  else begin
    errors++;
    $display("Old item still offered to decode after a redirect");
  end

  // ======================================================================
  // Stimulus
  // ======================================================================
  task automatic redirect_to(input logic fl, input logic [31:0] fpc, input logic tr,
                             input logic [31:0] tv, input logic c, input logic be,
                             input logic [31:0] ba);
    @(posedge clk_i);
    #1;
    flush_i       = fl;
    flush_pc_i    = fpc;
    trap_active_i = tr;
    mtvec_i       = tv;
    misa_c_i      = c;
    bkpt_en_i     = be;
    bkpt_addr_i   = ba;
    @(posedge clk_i);
    #1;
    flush_i       = 1'b0;
    trap_active_i = 1'b0;
  endtask

  task automatic wait_outputs(input int n);
    int target;
    @(posedge clk_i);
    target = n_out + n;
    while (n_out < target) begin
      @(posedge clk_i);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    int errs;
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    flush_pc_i      = '0;
    trap_active_i   = 1'b0;
    mtvec_i         = '0;
    misa_c_i        = 1'b0;
    bkpt_en_i       = 1'b0;
    bkpt_addr_i     = '0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_data_i  = '0;
    out_ready_i     = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    errs = errors;
    wait_outputs(20);
    end_test("reset_sequence", errs);

    // Mixed lengths, then a 32-bit op across a word edge at 0x300A
    errs = errors;
    redirect_to(1'b1, 32'h2000, 1'b0, '0, 1'b1, 1'b0, '0);
    wait_outputs(40);
    redirect_to(1'b1, 32'h300A, 1'b0, '0, 1'b1, 1'b0, '0);
    wait_outputs(4);
    end_test("compressed_mix", errs);

    errs = errors;
    redirect_to(1'b1, 32'h2400, 1'b0, '0, 1'b1, 1'b0, '0);
    wait_outputs(150);
    end_test("random_backpressure", errs);

    errs = errors;
    redirect_to(1'b1, 32'h1100, 1'b0, '0, 1'b0, 1'b0, '0);
    wait_outputs(3);
    redirect_to(1'b0, '0, 1'b1, 32'h1200, 1'b0, 1'b0, '0);
    wait_outputs(3);
    redirect_to(1'b1, 32'h1300, 1'b1, 32'h1400, 1'b0, 1'b0, '0);
    wait_outputs(3);
    // Back to back, the second one wins
    redirect_to(1'b1, 32'h1500, 1'b0, '0, 1'b0, 1'b0, '0);
    redirect_to(1'b0, '0, 1'b1, 32'h1600, 1'b0, 1'b0, '0);
    wait_outputs(3);
    end_test("redirects", errs);

    errs = errors;
    redirect_to(1'b1, 32'h3000, 1'b0, '0, 1'b1, 1'b0, '0);
    wait_outputs(4);
    redirect_to(1'b1, 32'h0002_0000, 1'b0, '0, 1'b1, 1'b0, '0);
    wait_outputs(2);
    redirect_to(1'b1, 32'h1002, 1'b0, '0, 1'b0, 1'b0, '0);
    wait_outputs(2);
    // Breakpoint outranks the access fault on the same PC
    redirect_to(1'b1, 32'h0002_0000, 1'b0, '0, 1'b1, 1'b1, 32'h0002_0000);
    wait_outputs(2);
    end_test("exceptions", errs);

    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
fetch_pkg.sv
fetch_pc_gen.sv
fetch_align.sv
fetch_exc_check.sv
fetch_top.sv
tb_fetch.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_fetch -o tb_fetch_sim \
  || exit 1
out="$(./obj_dir/tb_fetch_sim)"
echo "$out"
echo "$out" | grep -qx "All tests passed" && exit 0 || exit 1
